/* sim.f */
copper_pkg.sv
copper_apb_regs.sv
copper_prog_mem.sv
copper_fetch.sv
copper_exec.sv
copper_top.sv
copper_tb_clk.sv
copper_properties.sv
copper_tb.sv

/* Bender.yml */
package:
  name: copper

sources:
  - copper_pkg.sv
  - copper_apb_regs.sv
  - copper_prog_mem.sv
  - copper_fetch.sv
  - copper_exec.sv
  - copper_top.sv
  - target: simulation
    files:
      - copper_tb_clk.sv
      - copper_properties.sv
      - copper_tb.sv

/* copper_tb.sv */
`timescale 1ns/1ps

module copper_tb;
    import copper_pkg::*;

    localparam int H_TOT = 40;
    localparam int V_TOT = 20;
    localparam int TIMEOUT = 2000;
    localparam logic [31:0] EN = 32'h1 << CTRL_EN_BIT;
    // WAIT execute, then MOVER read, latch, precompute and execute before the write
    localparam int WR_LAT = 6;

    logic clk;
    logic copp_reset;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic psel_i;
    logic penable_i;
    logic pwrite_i;
    logic [APB_DATA_W-1:0] pwdata_i;
    logic pready_o;
    logic [APB_DATA_W-1:0] prdata_o;
    logic pslverr_o;
    logic [POS_W-1:0] h_count_i;
    logic [POS_W-1:0] v_count_i;
    logic xr_wr_en_o;
    logic [XR_ADDR_W-1:0] xr_wr_addr_o;
    logic [DATA_W-1:0] xr_wr_data_o;

    // Observed and expected register writes
    logic [XR_ADDR_W-1:0] got_addr [$];
    logic [DATA_W-1:0] got_data [$];
    int got_pos [$];
    logic [XR_ADDR_W-1:0] exp_addr [$];
    logic [DATA_W-1:0] exp_data [$];

    logic [31:0] rdata;
    logic rerr;

    copper_tb_clk u_clk (
        .clk        (clk),
        .copp_reset (copp_reset)
    );

    copper_top #(
        .H_TOTAL    (H_TOT),
        .V_TOTAL    (V_TOT)
    ) dut (
        .clk            (clk),
        .copp_reset     (copp_reset),
        .paddr_i        (paddr_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .pwdata_i       (pwdata_i),
        .pready_o       (pready_o),
        .prdata_o       (prdata_o),
        .pslverr_o      (pslverr_o),
        .h_count_i      (h_count_i),
        .v_count_i      (v_count_i),
        .xr_wr_en_o     (xr_wr_en_o),
        .xr_wr_addr_o   (xr_wr_addr_o),
        .xr_wr_data_o   (xr_wr_data_o)
    );

    bind copper_top copper_properties u_props (
        .clk            (clk),
        .copp_reset     (copp_reset),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pready_o       (pready_o),
        .xr_wr_en_o     (xr_wr_en_o),
        .insn_valid     (insn_valid),
        .insn           (insn),
        .insn_done      (insn_done),
        .frame_restart  (frame_restart)
    );

    task automatic fail_now(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping on first error");
    endtask

    // Raster counter model, h wraps at 40, v at 20
    always @(posedge clk) begin
        if (copp_reset) begin
            h_count_i <= #1 '0;
            v_count_i <= #1 '0;
        end else if (h_count_i == H_TOT - 1) begin
            h_count_i <= #1 '0;
            v_count_i <= #1 ((v_count_i == V_TOT - 1) ? '0 : v_count_i + 1'b1);
        end else begin
            h_count_i <= #1 h_count_i + 1'b1;
        end
    end

    // Write capture with the raster position as a linear count
    always @(posedge clk) begin
        if (!copp_reset && xr_wr_en_o) begin
            got_addr.push_back(xr_wr_addr_o);
            got_data.push_back(xr_wr_data_o);
            got_pos.push_back(int'(v_count_i) * H_TOT + int'(h_count_i));
        end
    end

    always @(posedge clk) begin
        if (dut.u_props.failed) begin
            fail_now("a bound assertion failed");
        end
    end

    function automatic logic [31:0] enc_pos(input logic [3:0] op, input int v, input int h,
                                            input logic ign_h, input logic ign_v);
        return {op, 1'b0, 11'(v), 1'b0, 11'(h), 2'b00, ign_h, ign_v};
    endfunction

    function automatic logic [31:0] enc_xfer(input logic [3:0] op, input int target,
                                             input logic [15:0] data);
        return {op, 2'b00, 10'(target), data};
    endfunction

    task automatic apb_access(input logic [12:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] data, output logic err);
        int n;
        @(posedge clk);
        #1;
        paddr_i = addr;
        pwrite_i = wr;
        pwdata_i = wdata;
        psel_i = 1'b1;
        @(posedge clk);
        #1 penable_i = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 16) begin
                $display("APB slave never raised pready");
                fail_now("pready timeout");
            end
        end while (!pready_o);
        data = prdata_o;
        err = pslverr_o;
        #1;
        psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [12:0] addr, input logic [31:0] wdata);
        logic [31:0] d;
        logic e;
        apb_access(addr, 1'b1, wdata, d, e);
        assert (!e) else fail_now("unexpected pslverr on write");
    endtask

    // Wait for a raster position seen at a clock edge
    task automatic wait_pos(input int v, input int h);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Raster position never reached, the counter model is stuck");
                fail_now("position timeout");
            end
        end while (!(v_count_i == v && h_count_i == h));
    endtask

    // Load init_pc while disabled, run one frame from its start
    task automatic run_program(input int pc);
        apb_write(CTRL_ADDR, 32'(pc));
        wait_pos(V_TOT - 1, H_TOT - 5);
        wait_pos(0, 1);
        assert (got_addr.size() == 0) else fail_now("write while disabled");
        apb_write(CTRL_ADDR, EN | 32'(pc));
        // Enable bit reads back along with the initial PC
        apb_access(CTRL_ADDR, 1'b0, '0, rdata, rerr);
        assert (rdata == (EN | 32'(pc)) && !rerr) else fail_now("enable readback mismatch");
        wait_pos(V_TOT - 1, 20);
        apb_write(CTRL_ADDR, 32'(pc));
    endtask

    task automatic expect_write(input int a, input logic [15:0] d);
        exp_addr.push_back(8'(a));
        exp_data.push_back(d);
    endtask

    task automatic compare_writes();
        assert (got_addr.size() == exp_addr.size()) else fail_now("wrong number of writes");
        foreach (exp_addr[i]) begin
            assert (got_addr[i] == exp_addr[i]) else fail_now("wrong write address");
            assert (got_data[i] == exp_data[i]) else fail_now("wrong write data");
        end
    endtask

    task automatic check_pos_window(input int lo, input int hi);
        assert (got_pos.size() == 1) else fail_now("expected exactly one write");
        assert (got_pos[0] >= lo && got_pos[0] <= hi) else fail_now("write at wrong position");
    endtask

    task automatic clear_writes();
        got_addr.delete();
        got_data.delete();
        got_pos.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic load_word(input int idx, input logic [31:0] w);
        apb_write(PROG_BASE + 13'(4 * idx), w);
    endtask

    initial begin
        int n;
        paddr_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        pwdata_i = '0;
        h_count_i = '0;
        v_count_i = '0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 50) begin
                $display("Reset never released");
                fail_now("reset timeout");
            end
        end while (copp_reset);

        // Control register and address map
        apb_access(CTRL_ADDR, 1'b0, '0, rdata, rerr);
        assert (rdata == 32'h0 && !rerr) else fail_now("control not zero after reset");
        apb_write(CTRL_ADDR, 32'h7fff_7fff);
        apb_access(CTRL_ADDR, 1'b0, '0, rdata, rerr);
        assert (rdata == 32'h0000_03ff) else fail_now("control readback mismatch");
        apb_access(13'h004, 1'b0, '0, rdata, rerr);
        assert (rerr) else fail_now("no pslverr on undecoded read");
        apb_access(13'h008, 1'b1, 32'h1, rdata, rerr);
        assert (rerr) else fail_now("no pslverr on undecoded write");
        apb_access(PROG_BASE, 1'b0, '0, rdata, rerr);
        assert (rerr) else fail_now("no pslverr on program read");
        apb_access(PROG_BASE + 13'h2, 1'b1, '0, rdata, rerr);
        assert (rerr) else fail_now("no pslverr on unaligned program write");
        apb_write(CTRL_ADDR, 32'h0);

        // MOVER sequence at 0
        load_word(0, enc_xfer(OP_MOVER, 8'h11, 16'h1234));
        load_word(1, enc_xfer(OP_MOVER, 8'h22, 16'habcd));
        load_word(2, enc_xfer(OP_MOVER, 8'h33, 16'h0f0f));
        load_word(3, enc_pos(OP_WAIT, 0, 0, 1'b1, 1'b1));
        // WAIT on both axes at 10
        load_word(10, enc_pos(OP_WAIT, 10, 12, 1'b0, 1'b0));
        load_word(11, enc_xfer(OP_MOVER, 8'h40, 16'h4000));
        load_word(12, enc_pos(OP_WAIT, 0, 0, 1'b1, 1'b1));
        // Horizontal ignored at 20
        load_word(20, enc_pos(OP_WAIT, 10, 39, 1'b1, 1'b0));
        load_word(21, enc_xfer(OP_MOVER, 8'h41, 16'h4100));
        load_word(22, enc_pos(OP_WAIT, 0, 0, 1'b1, 1'b1));
        // Vertical ignored at 30
        load_word(30, enc_pos(OP_WAIT, 15, 12, 1'b0, 1'b1));
        load_word(31, enc_xfer(OP_MOVER, 8'h42, 16'h4200));
        load_word(32, enc_pos(OP_WAIT, 0, 0, 1'b1, 1'b1));
        // SKIP reached then not reached at 40
        load_word(40, enc_pos(OP_SKIP, 0, 0, 1'b0, 1'b0));
        load_word(41, enc_xfer(OP_MOVER, 8'h50, 16'h5000));
        load_word(42, enc_xfer(OP_MOVER, 8'h51, 16'h5100));
        load_word(43, enc_pos(OP_SKIP, 18, 0, 1'b0, 1'b0));
        load_word(44, enc_xfer(OP_MOVER, 8'h52, 16'h5200));
        load_word(45, enc_pos(OP_WAIT, 0, 0, 1'b1, 1'b1));
        // JMP over a MOVER, then an illegal opcode as no-op
        load_word(50, enc_xfer(OP_JMP, 52, 16'h0));
        load_word(51, enc_xfer(OP_MOVER, 8'h60, 16'h6000));
        load_word(52, enc_xfer(OP_MOVER, 8'h61, 16'h6100));
        load_word(53, enc_xfer(4'b0011, 8'h63, 16'h6300));
        load_word(54, enc_xfer(OP_MOVER, 8'h62, 16'h6200));
        load_word(55, enc_pos(OP_WAIT, 0, 0, 1'b1, 1'b1));
        // Two one-write programs for restart
        load_word(60, enc_xfer(OP_MOVER, 8'h70, 16'haaaa));
        load_word(61, enc_pos(OP_WAIT, 0, 0, 1'b1, 1'b1));
        load_word(70, enc_xfer(OP_MOVER, 8'h71, 16'hbbbb));
        load_word(71, enc_pos(OP_WAIT, 0, 0, 1'b1, 1'b1));

        run_program(0);
        expect_write(8'h11, 16'h1234);
        expect_write(8'h22, 16'habcd);
        expect_write(8'h33, 16'h0f0f);
        compare_writes();
        clear_writes();

        // Conditions first hold at 412, 400 and 12
        run_program(10);
        check_pos_window(10 * H_TOT + 12 + WR_LAT, 10 * H_TOT + 30);
        clear_writes();
        run_program(20);
        check_pos_window(10 * H_TOT + WR_LAT, 10 * H_TOT + 18);
        clear_writes();
        run_program(30);
        check_pos_window(12 + WR_LAT, 30);
        clear_writes();

        run_program(40);
        expect_write(8'h51, 16'h5100);
        expect_write(8'h52, 16'h5200);
        compare_writes();
        clear_writes();

        run_program(50);
        expect_write(8'h61, 16'h6100);
        expect_write(8'h62, 16'h6200);
        compare_writes();
        clear_writes();

        // Restart repeats the program, new init_pc takes effect next frame
        apb_write(CTRL_ADDR, 32'd60);
        wait_pos(V_TOT - 1, H_TOT - 5);
        wait_pos(0, 1);
        apb_write(CTRL_ADDR, EN | 32'd60);
        wait_pos(10, 0);
        apb_write(CTRL_ADDR, EN | 32'd70);
        wait_pos(5, 0);
        wait_pos(5, 0);
        wait_pos(V_TOT - 1, 20);
        apb_write(CTRL_ADDR, 32'd70);
        expect_write(8'h70, 16'haaaa);
        expect_write(8'h71, 16'hbbbb);
        expect_write(8'h71, 16'hbbbb);
        compare_writes();
        clear_writes();

        repeat (4) @(posedge clk);
        if (dut.u_props.failed) begin
            $display("SIMULATION FAILED");
            $fatal(1, "bound assertion failed at the end");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* copper_properties.sv */
`timescale 1ns/1ps

module copper_properties (
    input  logic                clk,
    input  logic                copp_reset,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pready_o,
    input  logic                xr_wr_en_o,
    input  logic                insn_valid,
    input  copper_pkg::copper_insn_t insn,
    input  logic                insn_done,
    input  logic                frame_restart
);
    import copper_pkg::*;

    // Raised by any failing property, watched by the testbench
    logic failed = 1'b0;
    logic mover_done;

    assign mover_done = insn_done && (insn.pos.op == OP_MOVER);

    // APB has no wait states
    a_pready: assert property (@(posedge clk) psel_i && penable_i |-> pready_o)
        else begin failed = 1'b1; $error("pready low in an access phase"); end

    // Write strobe is a single cycle
    a_wr_pulse: assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr_en_o |=> !xr_wr_en_o)
        else begin failed = 1'b1; $error("register write longer than one cycle"); end

    // Every write follows a finished MOVER
    a_wr_cause: assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr_en_o |-> $past(mover_done && !frame_restart))
        else begin failed = 1'b1; $error("register write without a MOVER"); end

    // Every finished MOVER writes in the next cycle
    a_mover_wr: assert property (@(posedge clk) disable iff (copp_reset)
        mover_done && !frame_restart |=> xr_wr_en_o)
        else begin failed = 1'b1; $error("MOVER without a register write"); end

    // Restart drops the instruction and any write
    a_restart: assert property (@(posedge clk) disable iff (copp_reset)
        frame_restart |=> !xr_wr_en_o && !insn_valid)
        else begin failed = 1'b1; $error("frame restart left activity behind"); end

    // Fetch holds the instruction until exec finishes it
    a_hold: assert property (@(posedge clk) disable iff (copp_reset)
        insn_valid && !insn_done && !frame_restart |=> insn_valid && $stable(insn))
        else begin failed = 1'b1; $error("instruction dropped before done"); end

    // Quiet outputs right after reset
    a_reset: assert property (@(posedge clk) copp_reset |=> !xr_wr_en_o && !insn_valid)
        else begin failed = 1'b1; $error("activity after reset"); end

endmodule

/* copper_tb_clk.sv */
`timescale 1ns/1ps

module copper_tb_clk (
    output logic clk,
    output logic copp_reset
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for 8 cycles, released just after an edge
    initial begin
        copp_reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 copp_reset = 1'b0;
    end

endmodule

/* copper_top.sv */
`timescale 1ns/1ps

module copper_top #(
    parameter int H_TOTAL = 1056,
    parameter int V_TOTAL = 525
) (
    input  logic                                clk,
    input  logic                                copp_reset,
    input  logic [copper_pkg::APB_ADDR_W-1:0]   paddr_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [copper_pkg::APB_DATA_W-1:0]   pwdata_i,
    output logic                                pready_o,
    output logic [copper_pkg::APB_DATA_W-1:0]   prdata_o,
    output logic                                pslverr_o,
    input  logic [copper_pkg::POS_W-1:0]        h_count_i,
    input  logic [copper_pkg::POS_W-1:0]        v_count_i,
    output logic                                xr_wr_en_o,
    output logic [copper_pkg::XR_ADDR_W-1:0]    xr_wr_addr_o,
    output logic [copper_pkg::DATA_W-1:0]       xr_wr_data_o
);
    import copper_pkg::*;

    // Control from the host
    logic copper_en;
    logic [PC_W-1:0] init_pc;

    // Host side of program memory
    logic prog_wr_en;
    logic [PC_W-1:0] prog_wr_addr;
    logic [INSN_W-1:0] prog_wr_data;

    // Fetch side of program memory
    logic prog_rd_en;
    logic [PC_W-1:0] prog_rd_addr;
    copper_insn_t prog_rd_data;

    // Fetch to exec handshake
    logic insn_valid;
    copper_insn_t insn;
    logic insn_done;
    logic pc_skip;
    logic pc_load;
    logic [PC_W-1:0] pc_target;
    logic frame_restart;

    copper_apb_regs u_regs (
        .clk            (clk),
        .copp_reset     (copp_reset),
        .paddr_i        (paddr_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .pwdata_i       (pwdata_i),
        .pready_o       (pready_o),
        .prdata_o       (prdata_o),
        .pslverr_o      (pslverr_o),
        .copper_en_o    (copper_en),
        .init_pc_o      (init_pc),
        .prog_wr_en_o   (prog_wr_en),
        .prog_wr_addr_o (prog_wr_addr),
        .prog_wr_data_o (prog_wr_data)
    );

    copper_prog_mem u_mem (
        .clk        (clk),
        .wr_en_i    (prog_wr_en),
        .wr_addr_i  (prog_wr_addr),
        .wr_data_i  (prog_wr_data),
        .rd_en_i    (prog_rd_en),
        .rd_addr_i  (prog_rd_addr),
        .rd_data_o  (prog_rd_data)
    );

    // Raster timing only matters to the restart detector
    copper_fetch #(
        .H_TOTAL    (H_TOTAL),
        .V_TOTAL    (V_TOTAL)
    ) u_fetch (
        .clk                (clk),
        .copp_reset         (copp_reset),
        .copper_en_i        (copper_en),
        .init_pc_i          (init_pc),
        .h_count_i          (h_count_i),
        .v_count_i          (v_count_i),
        .prog_rd_data_i     (prog_rd_data),
        .insn_done_i        (insn_done),
        .pc_skip_i          (pc_skip),
        .pc_load_i          (pc_load),
        .pc_target_i        (pc_target),
        .prog_rd_en_o       (prog_rd_en),
        .prog_rd_addr_o     (prog_rd_addr),
        .insn_valid_o       (insn_valid),
        .insn_o             (insn),
        .frame_restart_o    (frame_restart)
    );

    copper_exec u_exec (
        .clk                (clk),
        .copp_reset         (copp_reset),
        .frame_restart_i    (frame_restart),
        .insn_valid_i       (insn_valid),
        .insn_i             (insn),
        .h_count_i          (h_count_i),
        .v_count_i          (v_count_i),
        .insn_done_o        (insn_done),
        .pc_skip_o          (pc_skip),
        .pc_load_o          (pc_load),
        .pc_target_o        (pc_target),
        .xr_wr_en_o         (xr_wr_en_o),
        .xr_wr_addr_o       (xr_wr_addr_o),
        .xr_wr_data_o       (xr_wr_data_o)
    );

endmodule

/* copper_exec.sv */
`timescale 1ns/1ps

module copper_exec (
    input  logic                                clk,
    input  logic                                copp_reset,
    input  logic                                frame_restart_i,
    input  logic                                insn_valid_i,
    input  copper_pkg::copper_insn_t            insn_i,
    input  logic [copper_pkg::POS_W-1:0]        h_count_i,
    input  logic [copper_pkg::POS_W-1:0]        v_count_i,
    output logic                                insn_done_o,
    output logic                                pc_skip_o,
    output logic                                pc_load_o,
    output logic [copper_pkg::PC_W-1:0]         pc_target_o,
    output logic                                xr_wr_en_o,
    output logic [copper_pkg::XR_ADDR_W-1:0]    xr_wr_addr_o,
    output logic [copper_pkg::DATA_W-1:0]       xr_wr_data_o
);
    import copper_pkg::*;

    // Idle also serves as precompute whenever an instruction is valid
    localparam logic EX_IDLE = 1'b0;
    localparam logic EX_EXEC = 1'b1;

    logic state;
    logic precomp;
    logic v_reached;
    logic h_reached;
    logic pos_ok;
    logic ign_both;
    opcode_t opcode;

    // Same opcode bits in both views
    assign opcode = insn_i.pos.op;

    assign precomp = (state == EX_IDLE) && insn_valid_i;

    // Position test, each flag relaxes only its own axis
    assign pos_ok = (insn_i.pos.ign_v || v_reached) && (insn_i.pos.ign_h || h_reached);
    // WAIT with both flags set waits for end of frame
    assign ign_both = insn_i.pos.ign_v && insn_i.pos.ign_h;

    // JMP target straight from the transfer view
    assign pc_target_o = insn_i.xfer.target[PC_W-1:0];

    // Execute decode, all results live for this cycle only
    always_comb begin
        insn_done_o = 1'b0;
        pc_skip_o = 1'b0;
        pc_load_o = 1'b0;
        if (state == EX_EXEC) begin
            case (opcode)
                OP_WAIT: begin
                    insn_done_o = pos_ok && !ign_both;
                end
                OP_SKIP: begin
                    insn_done_o = 1'b1;
                    pc_skip_o = pos_ok;
                end
                OP_JMP: begin
                    insn_done_o = 1'b1;
                    pc_load_o = 1'b1;
                end
                default: begin
                    // MOVER, and illegal opcodes as a no-op
                    insn_done_o = 1'b1;
                end
            endcase
        end
    end

    // Control state and write strobe
    always_ff @(posedge clk) begin
        if (copp_reset || frame_restart_i) begin
            // Restart drops the instruction and any pending write
            state <= EX_IDLE;
            xr_wr_en_o <= 1'b0;
        end else begin
            xr_wr_en_o <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (insn_valid_i) begin
                        state <= EX_EXEC;
                    end
                end
                default: begin
                    // Unfinished WAIT goes back through precompute
                    state <= EX_IDLE;
                    if (opcode == OP_MOVER) begin
                        xr_wr_en_o <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Compare results, registered to keep the adders off the decode path
    always_ff @(posedge clk) begin
        if (precomp) begin
            v_reached <= v_count_i >= insn_i.pos.v_pos;
            h_reached <= h_count_i >= insn_i.pos.h_pos;
        end
    end

    // Register write payload
    always_ff @(posedge clk) begin
        if (state == EX_EXEC && opcode == OP_MOVER) begin
            xr_wr_addr_o <= insn_i.xfer.target[XR_ADDR_W-1:0];
            xr_wr_data_o <= insn_i.xfer.data;
        end
    end

endmodule

/* copper_fetch.sv */
`timescale 1ns/1ps

module copper_fetch #(
    parameter int H_TOTAL = 1056,
    parameter int V_TOTAL = 525
) (
    input  logic                            clk,
    input  logic                            copp_reset,
    input  logic                            copper_en_i,
    input  logic [copper_pkg::PC_W-1:0]     init_pc_i,
    input  logic [copper_pkg::POS_W-1:0]    h_count_i,
    input  logic [copper_pkg::POS_W-1:0]    v_count_i,
    input  copper_pkg::copper_insn_t        prog_rd_data_i,
    input  logic                            insn_done_i,
    input  logic                            pc_skip_i,
    input  logic                            pc_load_i,
    input  logic [copper_pkg::PC_W-1:0]     pc_target_i,
    output logic                            prog_rd_en_o,
    output logic [copper_pkg::PC_W-1:0]     prog_rd_addr_o,
    output logic                            insn_valid_o,
    output copper_pkg::copper_insn_t        insn_o,
    output logic                            frame_restart_o
);
    import copper_pkg::*;

    // Restart point, a few clocks before the frame wraps
    localparam logic [POS_W-1:0] RESTART_H = POS_W'(H_TOTAL - 5);
    localparam logic [POS_W-1:0] RESTART_V = POS_W'(V_TOTAL - 1);

    // Fetch states
    localparam logic [1:0] F_INIT  = 2'd0;
    localparam logic [1:0] F_READ  = 2'd1;
    localparam logic [1:0] F_LATCH = 2'd2;
    localparam logic [1:0] F_HOLD  = 2'd3;

    logic [1:0] state;
    logic [PC_W-1:0] pc;

    // Shared with exec
    assign frame_restart_o = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);

    // Memory read is issued only in READ
    assign prog_rd_en_o = (state == F_READ);
    assign prog_rd_addr_o = pc;

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state <= F_INIT;
            pc <= '0;
            insn_valid_o <= 1'b0;
        end else if (frame_restart_o) begin
            // New frame starts over at the host's initial PC
            state <= F_INIT;
            pc <= init_pc_i;
            insn_valid_o <= 1'b0;
        end else begin
            case (state)
                F_INIT: begin
                    // Idle until the host enables the copper
                    if (copper_en_i) begin
                        state <= F_READ;
                    end
                end
                F_READ: begin
                    // PC moves on as soon as the read goes out
                    pc <= pc + 1'b1;
                    state <= F_LATCH;
                end
                F_LATCH: begin
                    // Memory data arrives this cycle
                    insn_valid_o <= 1'b1;
                    state <= F_HOLD;
                end
                F_HOLD: begin
                    if (insn_done_i) begin
                        insn_valid_o <= 1'b0;
                        // Jump wins over skip, exec never asks for both
                        if (pc_load_i) begin
                            pc <= pc_target_i;
                        end else if (pc_skip_i) begin
                            // PC already points past this word
                            pc <= pc + 1'b1;
                        end
                        // Stop fetching once disabled
                        state <= copper_en_i ? F_READ : F_INIT;
                    end
                end
                default: begin
                    state <= F_INIT;
                end
            endcase
        end
    end

    // Instruction latch, held steady for exec until done
    always_ff @(posedge clk) begin
        if (state == F_LATCH) begin
            insn_o <= prog_rd_data_i;
        end
    end

endmodule

/* copper_prog_mem.sv */
`timescale 1ns/1ps

module copper_prog_mem (
    input  logic                            clk,
    input  logic                            wr_en_i,
    input  logic [copper_pkg::PC_W-1:0]     wr_addr_i,
    input  logic [copper_pkg::INSN_W-1:0]   wr_data_i,
    input  logic                            rd_en_i,
    input  logic [copper_pkg::PC_W-1:0]     rd_addr_i,
    output copper_pkg::copper_insn_t        rd_data_o
);
    import copper_pkg::*;

    localparam int DEPTH = 2 ** PC_W;

    // Copper list storage
    logic [INSN_W-1:0] mem [DEPTH];

    // Host write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Fetch read port, one cycle latency
    // Output holds its value between reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* copper_apb_regs.sv */
`timescale 1ns/1ps

module copper_apb_regs (
    input  logic                                clk,
    input  logic                                copp_reset,
    input  logic [copper_pkg::APB_ADDR_W-1:0]   paddr_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [copper_pkg::APB_DATA_W-1:0]   pwdata_i,
    output logic                                pready_o,
    output logic [copper_pkg::APB_DATA_W-1:0]   prdata_o,
    output logic                                pslverr_o,
    output logic                                copper_en_o,
    output logic [copper_pkg::PC_W-1:0]         init_pc_o,
    output logic                                prog_wr_en_o,
    output logic [copper_pkg::PC_W-1:0]         prog_wr_addr_o,
    output logic [copper_pkg::INSN_W-1:0]       prog_wr_data_o
);
    import copper_pkg::*;

    logic access;
    logic ctrl_hit;
    logic prog_hit;
    logic access_ok;
    logic prog_write;

    // APB access phase, never extended
    assign access = psel_i && penable_i;
    assign pready_o = access;

    // Address decode
    assign ctrl_hit = (paddr_i == CTRL_ADDR);
    // Program window covers the upper 4 KiB, word aligned only
    assign prog_hit = (paddr_i >= PROG_BASE) && (paddr_i[1:0] == 2'b00);

    // Program memory is write only from the bus
    assign access_ok = ctrl_hit || (prog_hit && pwrite_i);
    assign pslverr_o = access && !access_ok;

    assign prog_write = access && pwrite_i && prog_hit;

    // Control readback, zeros in the reserved bits
    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i && ctrl_hit) begin
            prdata_o[CTRL_EN_BIT] = copper_en_o;
            prdata_o[PC_W-1:0] = init_pc_o;
        end
    end

    // Control register and write strobe
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en_o <= 1'b0;
            init_pc_o <= '0;
            prog_wr_en_o <= 1'b0;
        end else begin
            if (access && pwrite_i && ctrl_hit) begin
                copper_en_o <= pwdata_i[CTRL_EN_BIT];
                // Reserved bits 14 to 10 are not stored
                init_pc_o <= pwdata_i[PC_W-1:0];
            end
            // One cycle strobe per program write
            prog_wr_en_o <= prog_write;
        end
    end

    // Program write address and data, valid with the strobe
    always_ff @(posedge clk) begin
        if (prog_write) begin
            // Byte address to word index
            prog_wr_addr_o <= paddr_i[PC_W+1:2];
            prog_wr_data_o <= pwdata_i;
        end
    end

endmodule

/* copper_pkg.sv */
package copper_pkg;

    // Program address width, 1024 instructions
    localparam int PC_W = 10;
    // Raster coordinate width
    localparam int POS_W = 11;
    // Register port address and data widths
    localparam int XR_ADDR_W = 8;
    localparam int DATA_W = 16;
    // One program word holds one whole instruction
    localparam int INSN_W = 32;

    // APB bus widths
    localparam int APB_ADDR_W = 13;
    localparam int APB_DATA_W = 32;

    // APB byte address map
    localparam logic [APB_ADDR_W-1:0] CTRL_ADDR = 13'h0000;
    // Program word n lives at PROG_BASE + 4*n
    localparam logic [APB_ADDR_W-1:0] PROG_BASE = 13'h1000;

    // Control word layout, initial PC sits in the low PC_W bits
    localparam int CTRL_EN_BIT = 15;

    // Opcodes kept from the original copper instruction set
    typedef enum logic [3:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001
    } opcode_t;

    // One instruction word, read either as a position or as a transfer
    typedef union packed {
        // WAIT and SKIP
        struct packed {
            opcode_t            op;
            logic               rsvd_27;
            logic [POS_W-1:0]   v_pos;
            logic               rsvd_15;
            logic [POS_W-1:0]   h_pos;
            logic [1:0]         rsvd_3_2;
            logic               ign_h;
            logic               ign_v;
        } pos;
        // JMP and MOVER, target holds a PC or a register number
        struct packed {
            opcode_t            op;
            logic [1:0]         rsvd_27_26;
            logic [9:0]         target;
            logic [DATA_W-1:0]  data;
        } xfer;
    } copper_insn_t;

endpackage
